/* matmul_defs.svh */
`ifndef MATMUL_DEFS_SVH
`define MATMUL_DEFS_SVH

// one signed element per lane
`define MM_ELEM_W 8

// lanes per row word, also the array edge length
`define MM_LANES 4

`define MM_ADDR_W 7
`define MM_MEM_DEPTH 128

// input register, product register, accumulator
`define MM_MAC_STAGES 3

// the last operand pair still crosses lanes-1 rows and lanes-1 columns
// before reaching the far corner, then fills the mac pipeline
`define MM_DRAIN_WAIT (2 * (`MM_LANES - 1) + `MM_MAC_STAGES)

`endif

/* mm_arith_pkg.sv */
`default_nettype none

`include "matmul_defs.svh"

package mm_arith_pkg;

  typedef logic signed [`MM_ELEM_W-1:0] elem_t;
  typedef logic signed [2*`MM_ELEM_W-1:0] prod_t;

  // accumulators keep element width and wrap modulo 2**MM_ELEM_W
  typedef logic signed [`MM_ELEM_W-1:0] acc_t;

  localparam prod_t ELEM_MAX = prod_t'((2 ** (`MM_ELEM_W - 1)) - 1);
  localparam prod_t ELEM_MIN = -ELEM_MAX - prod_t'(1);

  // saturate a full product to the element range
  function automatic elem_t clamp_prod(input prod_t p);
    elem_t r;
    if (p > ELEM_MAX) begin
      r = elem_t'(ELEM_MAX);
    end else if (p < ELEM_MIN) begin
      r = elem_t'(ELEM_MIN);
    end else begin
      r = elem_t'(p);
    end
    return r;
  endfunction

endpackage

`default_nettype wire

/* mm_buffer_pkg.sv */
`default_nettype none

`include "matmul_defs.svh"

package mm_buffer_pkg;

  // bits that select a row inside a tile
  localparam int LANE_IDX_W = $clog2(`MM_LANES);

  typedef logic [`MM_ADDR_W-1:0] addr_t;
  typedef logic [`MM_LANES*`MM_ELEM_W-1:0] row_t;
  typedef logic [`MM_ADDR_W-LANE_IDX_W-1:0] tile_t;

endpackage

`default_nettype wire

/* row_ram.sv */
`timescale 1ns/1ns
`default_nettype none

`include "matmul_defs.svh"

module row_ram (
  input  logic                            clk,
  input  logic                            i_we,
  input  logic [`MM_ADDR_W-1:0]           i_addr,
  input  logic [`MM_LANES*`MM_ELEM_W-1:0] i_wdata,
  output logic [`MM_LANES*`MM_ELEM_W-1:0] o_rdata
);

  logic [`MM_LANES*`MM_ELEM_W-1:0] mem [`MM_MEM_DEPTH];

  // read-first: a read at the written address returns the old word
  always_ff @(posedge clk) begin
    if (i_we) begin
      mem[i_addr] <= i_wdata;
    end
    o_rdata <= mem[i_addr];
  end

  a_we_addr_known: assert property (
    @(posedge clk) i_we |-> !$isunknown(i_addr)
  );

endmodule

`default_nettype wire

/* operand_skew.sv */
`timescale 1ns/1ns
`default_nettype none

`include "matmul_defs.svh"

module operand_skew (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 i_en,
  input  mm_buffer_pkg::row_t  i_row,
  output mm_arith_pkg::elem_t  o_lane0,
  output mm_arith_pkg::elem_t  o_lane1,
  output mm_arith_pkg::elem_t  o_lane2,
  output mm_arith_pkg::elem_t  o_lane3
);

  mm_arith_pkg::elem_t lane_in  [`MM_LANES];
  mm_arith_pkg::elem_t lane_out [`MM_LANES];

  // zeros outside the feed window so old memory output stays out of the array
  always_comb begin
    for (int n = 0; n < `MM_LANES; n++) begin
      lane_in[n] = i_en ? mm_arith_pkg::elem_t'(i_row[n*`MM_ELEM_W +: `MM_ELEM_W]) : '0;
    end
  end

  assign lane_out[0] = lane_in[0];

  // lane n gets n register stages
  for (genvar n = 1; n < `MM_LANES; n++) begin : g_delay
    mm_arith_pkg::elem_t pipe [n];

    always_ff @(posedge clk) begin
      if (reset) begin
        for (int d = 0; d < n; d++) begin
          pipe[d] <= '0;
        end
      end else begin
        pipe[0] <= lane_in[n];
        for (int d = 1; d < n; d++) begin
          pipe[d] <= pipe[d-1];
        end
      end
    end

    assign lane_out[n] = pipe[n-1];
  end

  assign o_lane0 = lane_out[0];
  assign o_lane1 = lane_out[1];
  assign o_lane2 = lane_out[2];
  assign o_lane3 = lane_out[3];

endmodule

`default_nettype wire

/* mac_cell.sv */
`timescale 1ns/1ns
`default_nettype none

module mac_cell (
  input  logic                clk,
  input  logic                reset,
  input  logic                i_clear,
  input  mm_arith_pkg::elem_t i_a,
  input  mm_arith_pkg::elem_t i_b,
  output mm_arith_pkg::elem_t o_a,
  output mm_arith_pkg::elem_t o_b,
  output mm_arith_pkg::elem_t o_acc
);

  // stage 1, also the systolic forwarding registers
  mm_arith_pkg::elem_t a_q;
  mm_arith_pkg::elem_t b_q;

  // stage 2
  mm_arith_pkg::prod_t prod_w;
  mm_arith_pkg::prod_t prod_q;

  // stage 3
  mm_arith_pkg::acc_t  acc_q;

  // both operands signed, so the 16-bit context sign-extends them
  assign prod_w = a_q * b_q;

  always_ff @(posedge clk) begin
    if (reset || i_clear) begin
      a_q <= '0;
      b_q <= '0;
    end else begin
      a_q <= i_a;
      b_q <= i_b;
    end
  end

  always_ff @(posedge clk) begin
    if (reset || i_clear) begin
      prod_q <= '0;
    end else begin
      prod_q <= prod_w;
    end
  end

  // clamp first, then add with 8-bit wrap
  always_ff @(posedge clk) begin
    if (reset || i_clear) begin
      acc_q <= '0;
    end else begin
      acc_q <= acc_q + mm_arith_pkg::clamp_prod(prod_q);
    end
  end

  assign o_a   = a_q;
  assign o_b   = b_q;
  assign o_acc = acc_q;

endmodule

`default_nettype wire

/* systolic_array.sv */
`timescale 1ns/1ns
`default_nettype none

`include "matmul_defs.svh"

module systolic_array (
  input  logic                clk,
  input  logic                reset,
  input  logic                i_clear,
  input  mm_arith_pkg::elem_t i_row0,
  input  mm_arith_pkg::elem_t i_row1,
  input  mm_arith_pkg::elem_t i_row2,
  input  mm_arith_pkg::elem_t i_row3,
  input  mm_arith_pkg::elem_t i_col0,
  input  mm_arith_pkg::elem_t i_col1,
  input  mm_arith_pkg::elem_t i_col2,
  input  mm_arith_pkg::elem_t i_col3,
  output mm_arith_pkg::elem_t o_c [`MM_LANES][`MM_LANES]
);

  // a_w[r][c] enters cell (r,c) from the left, b_w[r][c] from above
  // the extra column and row hold what leaves the right and bottom edges
  mm_arith_pkg::elem_t a_w [`MM_LANES][`MM_LANES+1];
  mm_arith_pkg::elem_t b_w [`MM_LANES+1][`MM_LANES];

  assign a_w[0][0] = i_row0;
  assign a_w[1][0] = i_row1;
  assign a_w[2][0] = i_row2;
  assign a_w[3][0] = i_row3;

  assign b_w[0][0] = i_col0;
  assign b_w[0][1] = i_col1;
  assign b_w[0][2] = i_col2;
  assign b_w[0][3] = i_col3;

  for (genvar r = 0; r < `MM_LANES; r++) begin : g_row
    for (genvar c = 0; c < `MM_LANES; c++) begin : g_col
      mac_cell u_cell (
        .clk     (clk),
        .reset   (reset),
        .i_clear (i_clear),
        .i_a     (a_w[r][c]),
        .i_b     (b_w[r][c]),
        .o_a     (a_w[r][c+1]),
        .o_b     (b_w[r+1][c]),
        .o_acc   (o_c[r][c])
      );
    end
  end

endmodule

`default_nettype wire

/* result_drain.sv */
`timescale 1ns/1ns
`default_nettype none

`include "matmul_defs.svh"

module result_drain (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 i_go,
  input  mm_buffer_pkg::tile_t i_tile,
  input  mm_arith_pkg::elem_t  i_c [`MM_LANES][`MM_LANES],
  output logic                 o_we,
  output mm_buffer_pkg::addr_t o_addr,
  output mm_buffer_pkg::row_t  o_wdata,
  output logic                 o_last
);

  localparam int ROW_W = mm_buffer_pkg::LANE_IDX_W;

  mm_arith_pkg::elem_t  snap [`MM_LANES][`MM_LANES];
  mm_buffer_pkg::tile_t tile_q;
  logic                 active;
  logic [ROW_W-1:0]     row;

  always_ff @(posedge clk) begin
    if (reset) begin
      active <= 1'b0;
      row    <= '0;
    end else if (i_go) begin
      active <= 1'b1;
      row    <= '0;
    end else if (active) begin
      row <= row + 1'b1;
      if (row == ROW_W'(`MM_LANES - 1)) begin
        active <= 1'b0;
      end
    end
  end

  // snapshot frees the array for the next clear
  always_ff @(posedge clk) begin
    if (i_go) begin
      snap   <= i_c;
      tile_q <= i_tile;
    end
  end

  // lane j of the word is column j of the current row
  always_comb begin
    for (int j = 0; j < `MM_LANES; j++) begin
      o_wdata[j*`MM_ELEM_W +: `MM_ELEM_W] = snap[row][j];
    end
  end

  assign o_we   = active;
  assign o_addr = {tile_q, row};
  assign o_last = active && (row == ROW_W'(`MM_LANES - 1));

  a_go_when_idle: assert property (
    @(posedge clk) disable iff (reset) i_go |-> !active
  );

endmodule

`default_nettype wire

/* matmul_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

`include "matmul_defs.svh"

module matmul_ctrl (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 i_we_a,
  input  logic                 i_we_b,
  input  logic                 i_rd_c,
  input  logic                 i_start,
  input  mm_buffer_pkg::addr_t i_addr,
  input  mm_buffer_pkg::tile_t i_tile,
  input  logic                 i_drain_we,
  input  mm_buffer_pkg::addr_t i_drain_addr,
  input  logic                 i_drain_last,
  output mm_buffer_pkg::addr_t o_a_addr,
  output mm_buffer_pkg::addr_t o_b_addr,
  output mm_buffer_pkg::addr_t o_c_addr,
  output logic                 o_a_we,
  output logic                 o_b_we,
  output logic                 o_c_we,
  output logic                 o_feed,
  output logic                 o_clear,
  output logic                 o_drain_go,
  output logic                 o_rvalid,
  output logic                 o_busy,
  output logic                 o_done
);

  // run_cnt is 0 in the first busy cycle and LANES in the last feed cycle
  localparam int GO_AT = `MM_LANES + `MM_DRAIN_WAIT;
  localparam int CNT_W = $clog2(GO_AT + `MM_LANES + 2);
  localparam int ROW_W = mm_buffer_pkg::LANE_IDX_W;

  logic                 start_ok;
  logic                 rd_ok;
  logic                 rd_q;
  logic [CNT_W-1:0]     run_cnt;
  mm_buffer_pkg::tile_t tile_q;
  mm_buffer_pkg::addr_t host_addr_q;
  mm_buffer_pkg::addr_t run_addr;

  assign start_ok = i_start && !o_busy;
  assign rd_ok    = i_rd_c && !o_busy;

  always_ff @(posedge clk) begin
    if (reset) begin
      o_busy   <= 1'b0;
      o_done   <= 1'b0;
      o_clear  <= 1'b0;
      o_feed   <= 1'b0;
      rd_q     <= 1'b0;
      o_rvalid <= 1'b0;
      run_cnt  <= '0;
    end else begin
      if (start_ok) begin
        o_busy <= 1'b1;
      end else if (i_drain_last) begin
        o_busy <= 1'b0;
      end
      o_done  <= i_drain_last;
      o_clear <= start_ok;
      if (start_ok) begin
        run_cnt <= '0;
      end else if (o_busy) begin
        run_cnt <= run_cnt + 1'b1;
      end
      // the feed window lags the run address by one cycle like the memory data
      o_feed   <= o_busy && (run_cnt < CNT_W'(`MM_LANES));
      rd_q     <= rd_ok;
      o_rvalid <= rd_q;
    end
  end

  always_ff @(posedge clk) begin
    host_addr_q <= i_addr;
    if (start_ok) begin
      tile_q <= i_tile;
    end
  end

  // wraps through the tile while busy; only the first four reads are fed
  assign run_addr = {tile_q, run_cnt[ROW_W-1:0]};

  assign o_a_addr = o_busy ? run_addr : i_addr;
  assign o_b_addr = o_busy ? run_addr : i_addr;
  assign o_a_we   = i_we_a && !o_busy;
  assign o_b_we   = i_we_b && !o_busy;

  // drain writes and host reads never overlap in time
  assign o_c_addr = i_drain_we ? i_drain_addr : host_addr_q;
  assign o_c_we   = i_drain_we;

  assign o_drain_go = o_busy && (run_cnt == CNT_W'(GO_AT));

  a_done_one_cycle: assert property (
    @(posedge clk) disable iff (reset) o_done |=> !o_done
  );

  // host reads are gated by busy, so drain writes must stay inside the run
  a_drain_in_run: assert property (
    @(posedge clk) disable iff (reset) i_drain_we |-> o_busy
  );

endmodule

`default_nettype wire

/* matmul_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "matmul_defs.svh"

module matmul_top (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 i_we_a,
  input  logic                 i_we_b,
  input  logic                 i_rd_c,
  input  logic                 i_start,
  input  mm_buffer_pkg::addr_t i_addr,
  input  mm_buffer_pkg::tile_t i_tile,
  input  mm_buffer_pkg::row_t  i_wdata,
  output mm_buffer_pkg::row_t  o_rdata,
  output logic                 o_rvalid,
  output logic                 o_busy,
  output logic                 o_done
);

  localparam int ROW_W = mm_buffer_pkg::LANE_IDX_W;

  mm_buffer_pkg::addr_t a_addr;
  mm_buffer_pkg::addr_t b_addr;
  mm_buffer_pkg::addr_t c_addr;
  logic                 a_we;
  logic                 b_we;
  logic                 c_we;
  mm_buffer_pkg::row_t  a_rdata;
  mm_buffer_pkg::row_t  b_rdata;
  logic                 feed;
  logic                 clear;
  logic                 drain_go;
  logic                 drain_we;
  mm_buffer_pkg::addr_t drain_addr;
  mm_buffer_pkg::row_t  drain_wdata;
  logic                 drain_last;
  mm_arith_pkg::elem_t  row_lane [`MM_LANES];
  mm_arith_pkg::elem_t  col_lane [`MM_LANES];
  mm_arith_pkg::elem_t  c_res    [`MM_LANES][`MM_LANES];

  matmul_ctrl u_ctrl (
    .clk          (clk),
    .reset        (reset),
    .i_we_a       (i_we_a),
    .i_we_b       (i_we_b),
    .i_rd_c       (i_rd_c),
    .i_start      (i_start),
    .i_addr       (i_addr),
    .i_tile       (i_tile),
    .i_drain_we   (drain_we),
    .i_drain_addr (drain_addr),
    .i_drain_last (drain_last),
    .o_a_addr     (a_addr),
    .o_b_addr     (b_addr),
    .o_c_addr     (c_addr),
    .o_a_we       (a_we),
    .o_b_we       (b_we),
    .o_c_we       (c_we),
    .o_feed       (feed),
    .o_clear      (clear),
    .o_drain_go   (drain_go),
    .o_rvalid     (o_rvalid),
    .o_busy       (o_busy),
    .o_done       (o_done)
  );

  row_ram a_mem (
    .clk     (clk),
    .i_we    (a_we),
    .i_addr  (a_addr),
    .i_wdata (i_wdata),
    .o_rdata (a_rdata)
  );

  row_ram b_mem (
    .clk     (clk),
    .i_we    (b_we),
    .i_addr  (b_addr),
    .i_wdata (i_wdata),
    .o_rdata (b_rdata)
  );

  row_ram c_mem (
    .clk     (clk),
    .i_we    (c_we),
    .i_addr  (c_addr),
    .i_wdata (drain_wdata),
    .o_rdata (o_rdata)
  );

  // A words are columns of A, so their lanes feed the array rows
  operand_skew u_a_skew (
    .clk     (clk),
    .reset   (reset),
    .i_en    (feed),
    .i_row   (a_rdata),
    .o_lane0 (row_lane[0]),
    .o_lane1 (row_lane[1]),
    .o_lane2 (row_lane[2]),
    .o_lane3 (row_lane[3])
  );

  operand_skew u_b_skew (
    .clk     (clk),
    .reset   (reset),
    .i_en    (feed),
    .i_row   (b_rdata),
    .o_lane0 (col_lane[0]),
    .o_lane1 (col_lane[1]),
    .o_lane2 (col_lane[2]),
    .o_lane3 (col_lane[3])
  );

  systolic_array u_array (
    .clk     (clk),
    .reset   (reset),
    .i_clear (clear),
    .i_row0  (row_lane[0]),
    .i_row1  (row_lane[1]),
    .i_row2  (row_lane[2]),
    .i_row3  (row_lane[3]),
    .i_col0  (col_lane[0]),
    .i_col1  (col_lane[1]),
    .i_col2  (col_lane[2]),
    .i_col3  (col_lane[3]),
    .o_c     (c_res)
  );

  // while busy the upper A address bits carry the latched tile
  result_drain u_drain (
    .clk     (clk),
    .reset   (reset),
    .i_go    (drain_go),
    .i_tile  (a_addr[`MM_ADDR_W-1:ROW_W]),
    .i_c     (c_res),
    .o_we    (drain_we),
    .o_addr  (drain_addr),
    .o_wdata (drain_wdata),
    .o_last  (drain_last)
  );

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
  output logic o_clk,
  output logic o_reset
);

  // 10 ns period
  initial begin
    o_clk = 1'b0;
    forever begin
      #5 o_clk = ~o_clk;
    end
  end

  // reset held for the first 10 rising edges
  initial begin
    o_reset = 1'b1;
    repeat (10) @(posedge o_clk);
    o_reset <= 1'b0;
  end

endmodule

`default_nettype wire

/* tb_matmul.sv */
`timescale 1ns/1ns
`default_nettype none

`include "matmul_defs.svh"

module tb_matmul;

  localparam int LANES = `MM_LANES;
  localparam int EW = `MM_ELEM_W;
  localparam int NUM_TILES = 1 << $bits(mm_buffer_pkg::tile_t);
  localparam logic [31:0] LFSR_SEED = 32'h704392b5;
  localparam logic [31:0] LFSR_TAPS = 32'h80200003;
  // 13 runs plus one idle window of well under 80 cycles each for load, run and read back
  // doubled for margin
  localparam int CYCLE_LIMIT = 20 + 2 * 14 * 80;

  logic                 clk;
  logic                 reset;
  logic                 i_we_a;
  logic                 i_we_b;
  logic                 i_rd_c;
  logic                 i_start;
  mm_buffer_pkg::addr_t i_addr;
  mm_buffer_pkg::tile_t i_tile;
  mm_buffer_pkg::row_t  i_wdata;
  mm_buffer_pkg::row_t  o_rdata;
  logic                 o_rvalid;
  logic                 o_busy;
  logic                 o_done;

  int          err_value = 0;
  int          err_other = 0;
  int          checks_run = 0;
  int          rvalid_seen = 0;
  int          done_seen = 0;
  int          cycle_cnt = 0;
  logic [31:0] lfsr_state;

  // model copy of every tile where a_mdl[t][i][k] is A[i][k]
  logic signed [EW-1:0] a_mdl [NUM_TILES][LANES][LANES];
  logic signed [EW-1:0] b_mdl [NUM_TILES][LANES][LANES];

  tb_clock_gen u_clock_gen (
    .o_clk   (clk),
    .o_reset (reset)
  );

  matmul_top u_matmul_top (
    .clk      (clk),
    .reset    (reset),
    .i_we_a   (i_we_a),
    .i_we_b   (i_we_b),
    .i_rd_c   (i_rd_c),
    .i_start  (i_start),
    .i_addr   (i_addr),
    .i_tile   (i_tile),
    .i_wdata  (i_wdata),
    .o_rdata  (o_rdata),
    .o_rvalid (o_rvalid),
    .o_busy   (o_busy),
    .o_done   (o_done)
  );

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, the run did not finish", cycle_cnt);
      $display(">>> FAIL");
      $finish;
    end
  end

  always @(negedge clk) begin
    if (!reset && o_rvalid) begin
      rvalid_seen++;
    end
    if (!reset && o_done) begin
      done_seen++;
    end
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ LFSR_TAPS;
    end
    return n;
  endfunction

  // one LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int b = 0; b < n; b++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
  endfunction

  function automatic logic signed [EW-1:0] rand_elem();
    logic [31:0] v;
    v = rand_bits(EW);
    return v[EW-1:0];
  endfunction

  function automatic logic signed [EW-1:0] extreme_value(input logic [1:0] sel);
    logic signed [EW-1:0] v;
    case (sel)
      2'd0: v = 8'sd100;
      2'd1: v = -8'sd100;
      2'd2: v = 8'sd127;
      default: v = 8'sh80;
    endcase
    return v;
  endfunction

  // lane i is A[i][k]
  function automatic mm_buffer_pkg::row_t a_column_word(input int t, input int k);
    mm_buffer_pkg::row_t w;
    for (int i = 0; i < LANES; i++) begin
      w[i*EW +: EW] = a_mdl[t][i][k];
    end
    return w;
  endfunction

  // lane j is B[k][j]
  function automatic mm_buffer_pkg::row_t b_row_word(input int t, input int k);
    mm_buffer_pkg::row_t w;
    for (int j = 0; j < LANES; j++) begin
      w[j*EW +: EW] = b_mdl[t][k][j];
    end
    return w;
  endfunction

  // saturate each product to -128..127, then sum modulo 256
  function automatic mm_buffer_pkg::row_t model_c_row(input int t, input int i);
    mm_buffer_pkg::row_t w;
    int                  p;
    logic [EW-1:0]       sum;
    for (int j = 0; j < LANES; j++) begin
      sum = '0;
      for (int k = 0; k < LANES; k++) begin
        p = int'(a_mdl[t][i][k]) * int'(b_mdl[t][k][j]);
        if (p > 127) begin
          p = 127;
        end else if (p < -128) begin
          p = -128;
        end
        sum = sum + p[EW-1:0];
      end
      w[j*EW +: EW] = sum;
    end
    return w;
  endfunction

  task automatic compare_word(input string test, input logic [31:0] exp,
                              input logic [31:0] act);
    checks_run++;
    assert (act === exp) else begin
      err_value++;
      $display("CHECK FAILED %s: expected %h, actual %h", test, exp, act);
    end
  endtask

  task automatic expect_true(input string test, input logic cond, input string what);
    checks_run++;
    assert (cond === 1'b1) else begin
      err_other++;
      $display("%s: %s", test, what);
    end
  endtask

  task automatic write_row(input logic to_b, input int addr, input mm_buffer_pkg::row_t data);
    @(posedge clk);
    i_we_a  <= !to_b;
    i_we_b  <= to_b;
    i_addr  <= mm_buffer_pkg::addr_t'(addr);
    i_wdata <= data;
    @(posedge clk);
    i_we_a <= 1'b0;
    i_we_b <= 1'b0;
  endtask

  task automatic load_tile(input int t);
    for (int k = 0; k < LANES; k++) begin
      write_row(1'b0, LANES * t + k, a_column_word(t, k));
      write_row(1'b1, LANES * t + k, b_row_word(t, k));
    end
  endtask

  task automatic fill_random(input int t);
    for (int i = 0; i < LANES; i++) begin
      for (int k = 0; k < LANES; k++) begin
        a_mdl[t][i][k] = rand_elem();
        b_mdl[t][i][k] = rand_elem();
      end
    end
  endtask

  task automatic start_tile(input string test, input int t);
    @(posedge clk);
    i_start <= 1'b1;
    i_tile  <= mm_buffer_pkg::tile_t'(t);
    @(posedge clk);
    i_start <= 1'b0;
    @(negedge clk);
    expect_true(test, o_busy, "o_busy did not rise the cycle after i_start");
  endtask

  task automatic wait_done(input string test);
    int n;
    n = 0;
    while (!o_done && n < 100) begin
      @(negedge clk);
      n++;
    end
    expect_true(test, o_done, "o_done did not arrive within 100 cycles");
    expect_true(test, !o_busy, "o_busy still high in the o_done cycle");
  endtask

  // rvalid is expected on the second cycle after the strobe cycle
  task automatic read_row(input string test, input int addr, input mm_buffer_pkg::row_t exp);
    int lat;
    @(posedge clk);
    i_rd_c <= 1'b1;
    i_addr <= mm_buffer_pkg::addr_t'(addr);
    @(posedge clk);
    i_rd_c <= 1'b0;
    lat = 1;
    @(negedge clk);
    while (!o_rvalid && lat < 8) begin
      @(negedge clk);
      lat++;
    end
    compare_word({test, " read latency"}, 32'd2, lat);
    compare_word(test, exp, o_rdata);
  endtask

  task automatic check_tile(input string test, input int t);
    for (int i = 0; i < LANES; i++) begin
      read_row(test, LANES * t + i, model_c_row(t, i));
    end
  endtask

  task automatic identity_mult;
    for (int i = 0; i < LANES; i++) begin
      for (int k = 0; k < LANES; k++) begin
        a_mdl[0][i][k] = (i == k) ? 8'sd1 : 8'sd0;
        b_mdl[0][i][k] = rand_elem();
      end
    end
    load_tile(0);
    start_tile("identity", 0);
    wait_done("identity");
    // C must come back as B itself
    for (int i = 0; i < LANES; i++) begin
      read_row("identity", i, b_row_word(0, i));
    end
  endtask

  task automatic random_tiles;
    for (int t = 1; t <= 5; t++) begin
      fill_random(t);
      load_tile(t);
    end
    for (int t = 1; t <= 5; t++) begin
      start_tile("random", t);
      wait_done("random");
      check_tile("random", t);
    end
  endtask

  task automatic clamp_wrap;
    logic [31:0] r;
    // tile 6 has fixed columns of saturating and wrapping sums
    for (int i = 0; i < LANES; i++) begin
      for (int k = 0; k < LANES; k++) begin
        a_mdl[6][i][k] = extreme_value(2'(i));
        case (i)
          0: b_mdl[6][k][i] = 8'sd100;
          1: b_mdl[6][k][i] = -8'sd100;
          2: b_mdl[6][k][i] = (k % 2 == 0) ? 8'sd100 : -8'sd100;
          default: b_mdl[6][k][i] = 8'(k + 1);
        endcase
      end
    end
    // tile 7 mixes large magnitudes at random
    for (int i = 0; i < LANES; i++) begin
      for (int k = 0; k < LANES; k++) begin
        r = rand_bits(2);
        a_mdl[7][i][k] = extreme_value(r[1:0]);
        r = rand_bits(2);
        b_mdl[7][i][k] = extreme_value(r[1:0]);
      end
    end
    for (int t = 6; t <= 7; t++) begin
      load_tile(t);
      start_tile("clamp", t);
      wait_done("clamp");
      check_tile("clamp", t);
    end
  endtask

  task automatic busy_discipline;
    int rv0;
    int dn0;
    fill_random(8);
    fill_random(9);
    // identity B makes the C of tile 9 a copy of its A
    for (int i = 0; i < LANES; i++) begin
      for (int k = 0; k < LANES; k++) begin
        b_mdl[9][i][k] = (i == k) ? 8'sd1 : 8'sd0;
      end
    end
    load_tile(8);
    load_tile(9);
    rv0 = rvalid_seen;
    dn0 = done_seen;
    start_tile("busy", 8);
    write_row(1'b0, LANES * 9 + 1, 32'h5a5a_a5a5);
    @(posedge clk);
    i_rd_c <= 1'b1;
    i_addr <= mm_buffer_pkg::addr_t'(LANES * 9);
    @(posedge clk);
    i_rd_c  <= 1'b0;
    i_start <= 1'b1;
    i_tile  <= mm_buffer_pkg::tile_t'(9);
    @(posedge clk);
    i_start <= 1'b0;
    @(negedge clk);
    expect_true("busy", o_busy, "run ended before the ignored strobes were issued");
    wait_done("busy");
    // long enough for a wrongly accepted second run to finish
    repeat (40) @(negedge clk);
    compare_word("busy rvalid pulses", 32'd0, rvalid_seen - rv0);
    compare_word("busy done pulses", 32'd1, done_seen - dn0);
    check_tile("busy", 8);
    start_tile("busy", 9);
    wait_done("busy");
    check_tile("busy", 9);
  endtask

  task automatic back_to_back;
    fill_random(10);
    fill_random(11);
    load_tile(10);
    load_tile(11);
    start_tile("back-to-back", 10);
    wait_done("back-to-back");
    start_tile("back-to-back", 11);
    wait_done("back-to-back");
    check_tile("back-to-back", 10);
    check_tile("back-to-back", 11);
    // rerun after different data must give the same C
    start_tile("back-to-back", 10);
    wait_done("back-to-back");
    check_tile("back-to-back", 10);
  endtask

  initial begin
    lfsr_state = LFSR_SEED;
    i_we_a  <= 1'b0;
    i_we_b  <= 1'b0;
    i_rd_c  <= 1'b0;
    i_start <= 1'b0;
    i_addr  <= '0;
    i_tile  <= '0;
    i_wdata <= '0;
    @(negedge clk);
    while (reset) begin
      @(negedge clk);
    end
    expect_true("reset", !o_busy, "o_busy high after reset");
    expect_true("reset", !o_done, "o_done high after reset");
    expect_true("reset", !o_rvalid, "o_rvalid high after reset");
    identity_mult();
    random_tiles();
    clamp_wrap();
    busy_discipline();
    back_to_back();
    $display("summary: %0d checks, %0d value errors, %0d other errors",
             checks_run, err_value, err_other);
    if (err_value + err_other == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
+incdir+.
mm_arith_pkg.sv
mm_buffer_pkg.sv
row_ram.sv
operand_skew.sv
mac_cell.sv
systolic_array.sv
result_drain.sv
matmul_ctrl.sv
matmul_top.sv
tb_clock_gen.sv
tb_matmul.sv

/* Makefile */
TOP := tb_matmul
LOG := sim.log

.PHONY: all sim lint clean

all: sim

sim:
	verilator --binary --assert -Wno-fatal -f src.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -qx ">>> PASS" $(LOG)

lint:
	verilator --lint-only -Wall --timing --assert -f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
